// File: build.f
+incdir+tests
design/ExecPkg.sv
design/OperandIf.sv
design/OperandSelect.sv
design/IntegerUnit.sv
design/ExecuteCommit.sv
design/ExecuteStage.sv
tests/ExecuteStageTb.sv

// File: design/ExecPkg.sv
// Execute stage package
// shared widths, constants and encodings for the integer execute stage
package ExecPkg;

    localparam int XLEN = 32;
    // shift amount is taken from bits [XLEN_LOG2:0]
    localparam int XLEN_LOG2 = 4;
    localparam int INSN_SIZE = 4;
    localparam int REG_ADDR_WIDTH = 5;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] regAddr_t;

    typedef enum logic [3:0] {
        AluCommand_Add    = 4'd0,
        AluCommand_Sub    = 4'd1,
        AluCommand_Sll    = 4'd2,
        AluCommand_Slt    = 4'd3,
        AluCommand_Sltu   = 4'd4,
        AluCommand_Xor    = 4'd5,
        AluCommand_Srl    = 4'd6,
        AluCommand_Sra    = 4'd7,
        AluCommand_Or     = 4'd8,
        AluCommand_And    = 4'd9,
        AluCommand_Clear1 = 4'd10,
        AluCommand_Clear2 = 4'd11
    } AluCommand;

    typedef enum logic [1:0] {
        AluSrc1Type_Zero = 2'd0,
        AluSrc1Type_Pc   = 2'd1,
        AluSrc1Type_Reg  = 2'd2
    } AluSrc1Type;

    typedef enum logic [1:0] {
        AluSrc2Type_Zero = 2'd0,
        AluSrc2Type_Imm  = 2'd1,
        AluSrc2Type_Reg  = 2'd2
    } AluSrc2Type;

    typedef enum logic [2:0] {
        BranchType_Equal                = 3'd0,
        BranchType_NotEqual             = 3'd1,
        BranchType_LessThan             = 3'd2,
        BranchType_GreaterEqual         = 3'd3,
        BranchType_UnsignedLessThan     = 3'd4,
        BranchType_UnsignedGreaterEqual = 3'd5,
        BranchType_Always               = 3'd6
    } BranchType;

    typedef enum logic {
        WriteSrcType_Result = 1'b0,
        WriteSrcType_NextPc = 1'b1
    } WriteSrcType;

    typedef enum logic [1:0] {
        TrapOpType_None   = 2'd0,
        TrapOpType_Ecall  = 2'd1,
        TrapOpType_Ebreak = 2'd2
    } TrapOpType;

    // RISC-V privilege encoding where 2 is reserved
    typedef enum logic [1:0] {
        Privilege_User       = 2'd0,
        Privilege_Supervisor = 2'd1,
        Privilege_Machine    = 2'd3
    } Privilege;

    typedef enum logic [3:0] {
        ExceptionCode_IllegalInsn         = 4'd2,
        ExceptionCode_Breakpoint          = 4'd3,
        ExceptionCode_EcallFromUser       = 4'd8,
        ExceptionCode_EcallFromSupervisor = 4'd9,
        ExceptionCode_EcallFromMachine    = 4'd11
    } ExceptionCode;

endpackage

// File: design/ExecuteCommit.sv
// Execute commit
// trap detection, next PC and flush, output stage register and forwarding source
`timescale 1ns/1ps

module ExecuteCommit #(
    parameter int INSN_SIZE = ExecPkg::INSN_SIZE
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  opValid,
    input  ExecPkg::word_t        pc,
    input  ExecPkg::word_t        insn,
    input  ExecPkg::regAddr_t     dstAddr,
    input  logic                  regWrite,
    input  logic                  upstreamTrap,
    input  ExecPkg::TrapOpType    trapOp,
    input  ExecPkg::Privilege     privilege,
    input  ExecPkg::word_t        aluResult,
    input  ExecPkg::word_t        dstValue,
    input  logic                  branchCond,
    output logic                  fwdEnable,
    output ExecPkg::regAddr_t     fwdAddr,
    output ExecPkg::word_t        fwdValue,
    output logic                  resultValid,
    output ExecPkg::word_t        resultPc,
    output ExecPkg::regAddr_t     resultDstAddr,
    output logic                  resultRegWrite,
    output ExecPkg::word_t        resultValue,
    output logic                  branchTaken,
    output ExecPkg::word_t        nextPc,
    output logic                  flushReq,
    output logic                  trapValid,
    output ExecPkg::ExceptionCode trapCause,
    output ExecPkg::word_t        trapValue
);

    logic trapHit;
    ExecPkg::ExceptionCode causeNext;
    ExecPkg::word_t trapValueNext;
    logic trapNext;
    logic takenNext;
    logic regWriteNext;
    logic flushNext;
    ExecPkg::word_t nextPcNext;

    // upstream trap wins over ecall, ecall over ebreak
    always_comb begin
        trapHit = 1'b0;
        causeNext = ExecPkg::ExceptionCode_IllegalInsn;
        trapValueNext = '0;
        if (upstreamTrap) begin
            trapHit = 1'b1;
            trapValueNext = insn;
        end
        else if (trapOp == ExecPkg::TrapOpType_Ecall) begin
            trapHit = 1'b1;
            unique case (privilege)
                ExecPkg::Privilege_Machine:
                    causeNext = ExecPkg::ExceptionCode_EcallFromMachine;
                ExecPkg::Privilege_Supervisor:
                    causeNext = ExecPkg::ExceptionCode_EcallFromSupervisor;
                default:
                    causeNext = ExecPkg::ExceptionCode_EcallFromUser;
            endcase
        end
        else if (trapOp == ExecPkg::TrapOpType_Ebreak) begin
            trapHit = 1'b1;
            causeNext = ExecPkg::ExceptionCode_Breakpoint;
        end
    end

    always_comb begin
        trapNext = opValid && trapHit;
        takenNext = opValid && branchCond && !trapHit;
        regWriteNext = opValid && regWrite && !trapHit;
        flushNext = trapNext || takenNext;
        // branch target comes out of the ALU
        nextPcNext = takenNext ? aluResult : pc + ExecPkg::word_t'(INSN_SIZE);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            resultRegWrite <= 1'b0;
            branchTaken <= 1'b0;
            flushReq <= 1'b0;
            trapValid <= 1'b0;
        end
        else begin
            resultValid <= opValid;
            resultRegWrite <= regWriteNext;
            branchTaken <= takenNext;
            flushReq <= flushNext;
            trapValid <= trapNext;
        end
    end

    always_ff @(posedge clk) begin
        resultPc <= pc;
        resultDstAddr <= dstAddr;
        resultValue <= dstValue;
        nextPc <= nextPcNext;
        trapCause <= causeNext;
        trapValue <= trapValueNext;
    end

    // last committed write feeds the bypass
    always_comb begin
        fwdEnable = resultValid && resultRegWrite;
        fwdAddr = resultDstAddr;
        fwdValue = resultValue;
    end

endmodule

// File: design/ExecuteStage.sv
// Integer execute stage top level
// operand selection, integer unit and commit register behind plain ports
`timescale 1ns/1ps

module ExecuteStage #(
    parameter int INSN_SIZE = ExecPkg::INSN_SIZE
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  opValid,
    input  ExecPkg::word_t        pc,
    input  ExecPkg::word_t        insn,
    input  ExecPkg::AluCommand    aluCommand,
    input  ExecPkg::AluSrc1Type   aluSrc1Type,
    input  ExecPkg::AluSrc2Type   aluSrc2Type,
    input  ExecPkg::word_t        imm,
    input  logic                  isBranch,
    input  ExecPkg::BranchType    branchType,
    input  ExecPkg::WriteSrcType  writeSrc,
    input  logic                  regWrite,
    input  ExecPkg::regAddr_t     dstAddr,
    input  ExecPkg::regAddr_t     srcAddr1,
    input  ExecPkg::regAddr_t     srcAddr2,
    input  ExecPkg::word_t        srcValue1,
    input  ExecPkg::word_t        srcValue2,
    input  ExecPkg::TrapOpType    trapOp,
    input  ExecPkg::Privilege     privilege,
    input  logic                  upstreamTrap,
    output logic                  resultValid,
    output ExecPkg::word_t        resultPc,
    output ExecPkg::regAddr_t     resultDstAddr,
    output logic                  resultRegWrite,
    output ExecPkg::word_t        resultValue,
    output logic                  branchTaken,
    output ExecPkg::word_t        nextPc,
    output logic                  flushReq,
    output logic                  trapValid,
    output ExecPkg::ExceptionCode trapCause,
    output ExecPkg::word_t        trapValue
);

    ExecPkg::word_t aluResult;
    ExecPkg::word_t dstValue;
    logic branchCond;
    logic fwdEnable;
    ExecPkg::regAddr_t fwdAddr;
    ExecPkg::word_t fwdValue;

    OperandIf operands ();

    OperandSelect u_OperandSelect (
        .srcAddr1    (srcAddr1),
        .srcAddr2    (srcAddr2),
        .srcValue1   (srcValue1),
        .srcValue2   (srcValue2),
        .pc          (pc),
        .imm         (imm),
        .aluSrc1Type (aluSrc1Type),
        .aluSrc2Type (aluSrc2Type),
        .fwdEnable   (fwdEnable),
        .fwdAddr     (fwdAddr),
        .fwdValue    (fwdValue),
        .operands    (operands.source)
    );

    IntegerUnit #(
        .INSN_SIZE (INSN_SIZE)
    ) u_IntegerUnit (
        .operands   (operands.sink),
        .aluCommand (aluCommand),
        .isBranch   (isBranch),
        .branchType (branchType),
        .writeSrc   (writeSrc),
        .pc         (pc),
        .aluResult  (aluResult),
        .branchCond (branchCond),
        .dstValue   (dstValue)
    );

    // single register stage of the execute pipeline
    ExecuteCommit #(
        .INSN_SIZE (INSN_SIZE)
    ) u_ExecuteCommit (
        .clk            (clk),
        .reset          (reset),
        .opValid        (opValid),
        .pc             (pc),
        .insn           (insn),
        .dstAddr        (dstAddr),
        .regWrite       (regWrite),
        .upstreamTrap   (upstreamTrap),
        .trapOp         (trapOp),
        .privilege      (privilege),
        .aluResult      (aluResult),
        .dstValue       (dstValue),
        .branchCond     (branchCond),
        .fwdEnable      (fwdEnable),
        .fwdAddr        (fwdAddr),
        .fwdValue       (fwdValue),
        .resultValid    (resultValid),
        .resultPc       (resultPc),
        .resultDstAddr  (resultDstAddr),
        .resultRegWrite (resultRegWrite),
        .resultValue    (resultValue),
        .branchTaken    (branchTaken),
        .nextPc         (nextPc),
        .flushReq       (flushReq),
        .trapValid      (trapValid),
        .trapCause      (trapCause),
        .trapValue      (trapValue)
    );

endmodule

// File: design/IntegerUnit.sv
// Integer unit
// ALU, branch comparator and choice of the write-back value
`timescale 1ns/1ps

module IntegerUnit #(
    parameter int INSN_SIZE = ExecPkg::INSN_SIZE
) (
    OperandIf.sink               operands,
    input  ExecPkg::AluCommand   aluCommand,
    input  logic                 isBranch,
    input  ExecPkg::BranchType   branchType,
    input  ExecPkg::WriteSrcType writeSrc,
    input  ExecPkg::word_t       pc,
    output ExecPkg::word_t       aluResult,
    output logic                 branchCond,
    output ExecPkg::word_t       dstValue
);

    logic [ExecPkg::XLEN_LOG2:0] shamt;
    ExecPkg::word_t a;
    ExecPkg::word_t b;
    logic cmpResult;

    always_comb begin
        a = operands.aluSrc1;
        b = operands.aluSrc2;
        shamt = b[ExecPkg::XLEN_LOG2:0];
    end

    always_comb begin
        unique case (aluCommand)
            ExecPkg::AluCommand_Add:    aluResult = a + b;
            ExecPkg::AluCommand_Sub:    aluResult = a - b;
            ExecPkg::AluCommand_Sll:    aluResult = a << shamt;
            ExecPkg::AluCommand_Slt:    aluResult = {{(ExecPkg::XLEN-1){1'b0}},
                                                     $signed(a) < $signed(b)};
            ExecPkg::AluCommand_Sltu:   aluResult = {{(ExecPkg::XLEN-1){1'b0}}, a < b};
            ExecPkg::AluCommand_Xor:    aluResult = a ^ b;
            ExecPkg::AluCommand_Srl:    aluResult = a >> shamt;
            ExecPkg::AluCommand_Sra:    aluResult = ExecPkg::word_t'($signed(a) >>> shamt);
            ExecPkg::AluCommand_Or:     aluResult = a | b;
            ExecPkg::AluCommand_And:    aluResult = a & b;
            ExecPkg::AluCommand_Clear1: aluResult = a & ~b;
            ExecPkg::AluCommand_Clear2: aluResult = ~a & b;
            default:                    aluResult = '0;
        endcase
    end

    // comparator on forwarded register values, not on the ALU operands
    always_comb begin
        unique case (branchType)
            ExecPkg::BranchType_Equal:
                cmpResult = operands.cmpSrc1 == operands.cmpSrc2;
            ExecPkg::BranchType_NotEqual:
                cmpResult = operands.cmpSrc1 != operands.cmpSrc2;
            ExecPkg::BranchType_LessThan:
                cmpResult = $signed(operands.cmpSrc1) < $signed(operands.cmpSrc2);
            ExecPkg::BranchType_GreaterEqual:
                cmpResult = $signed(operands.cmpSrc1) >= $signed(operands.cmpSrc2);
            ExecPkg::BranchType_UnsignedLessThan:
                cmpResult = operands.cmpSrc1 < operands.cmpSrc2;
            ExecPkg::BranchType_UnsignedGreaterEqual:
                cmpResult = operands.cmpSrc1 >= operands.cmpSrc2;
            ExecPkg::BranchType_Always:
                cmpResult = 1'b1;
            default:
                cmpResult = 1'b0;
        endcase
        branchCond = isBranch && cmpResult;
    end

    // link value for jumps
    always_comb begin
        unique case (writeSrc)
            ExecPkg::WriteSrcType_NextPc: dstValue = pc + ExecPkg::word_t'(INSN_SIZE);
            default:                      dstValue = aluResult;
        endcase
    end

endmodule

// File: design/OperandIf.sv
// Operand bundle between operand selection and the integer unit
// carries the two ALU operands and the forwarded compare sources
`timescale 1ns/1ps

interface OperandIf;

    ExecPkg::word_t aluSrc1;
    ExecPkg::word_t aluSrc2;

    // forwarded register values for the branch comparator
    ExecPkg::word_t cmpSrc1;
    ExecPkg::word_t cmpSrc2;

    modport source (
        output aluSrc1,
        output aluSrc2,
        output cmpSrc1,
        output cmpSrc2
    );

    modport sink (
        input aluSrc1,
        input aluSrc2,
        input cmpSrc1,
        input cmpSrc2
    );

endinterface

// File: design/OperandSelect.sv
// Operand selection
// forwards the previous result into stale register sources and picks the ALU operands
`timescale 1ns/1ps

module OperandSelect (
    input  ExecPkg::regAddr_t   srcAddr1,
    input  ExecPkg::regAddr_t   srcAddr2,
    input  ExecPkg::word_t      srcValue1,
    input  ExecPkg::word_t      srcValue2,
    input  ExecPkg::word_t      pc,
    input  ExecPkg::word_t      imm,
    input  ExecPkg::AluSrc1Type aluSrc1Type,
    input  ExecPkg::AluSrc2Type aluSrc2Type,
    input  logic                fwdEnable,
    input  ExecPkg::regAddr_t   fwdAddr,
    input  ExecPkg::word_t      fwdValue,
    OperandIf.source            operands
);

    logic fwdHit1;
    logic fwdHit2;
    ExecPkg::word_t regValue1;
    ExecPkg::word_t regValue2;

    // x0 is hardwired, so a write to it never forwards
    always_comb begin
        fwdHit1 = fwdEnable && (fwdAddr == srcAddr1) && (fwdAddr != '0);
        fwdHit2 = fwdEnable && (fwdAddr == srcAddr2) && (fwdAddr != '0);
    end

    always_comb begin
        regValue1 = fwdHit1 ? fwdValue : srcValue1;
        regValue2 = fwdHit2 ? fwdValue : srcValue2;
    end

    // first operand
    always_comb begin
        unique case (aluSrc1Type)
            ExecPkg::AluSrc1Type_Zero: operands.aluSrc1 = '0;
            ExecPkg::AluSrc1Type_Pc:   operands.aluSrc1 = pc;
            ExecPkg::AluSrc1Type_Reg:  operands.aluSrc1 = regValue1;
            default:                   operands.aluSrc1 = '0;
        endcase
    end

    // second operand
    always_comb begin
        unique case (aluSrc2Type)
            ExecPkg::AluSrc2Type_Zero: operands.aluSrc2 = '0;
            ExecPkg::AluSrc2Type_Imm:  operands.aluSrc2 = imm;
            ExecPkg::AluSrc2Type_Reg:  operands.aluSrc2 = regValue2;
            default:                   operands.aluSrc2 = '0;
        endcase
    end

    // comparator always sees the register values
    always_comb begin
        operands.cmpSrc1 = regValue1;
        operands.cmpSrc2 = regValue2;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f build.f --top-module ExecuteStageTb -o simExecute \
    && ./obj_dir/simExecute > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }

grep -q "^Everything OK$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: tests/ExecuteModel.svh
// Execute stage reference model
// ALU, comparator and trap rules plus the last committed write for forwarding
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

typedef struct {
    logic valid;
    ExecPkg::word_t pc;
    ExecPkg::regAddr_t dstAddr;
    logic regWrite;
    ExecPkg::word_t value;
    logic taken;
    ExecPkg::word_t nextPc;
    logic flush;
    logic trap;
    ExecPkg::ExceptionCode cause;
    ExecPkg::word_t trapValue;
} ExpectedResult;

// last committed write, seen by the next operation
logic lastWriteValid;
ExecPkg::regAddr_t lastWriteAddr;
ExecPkg::word_t lastWriteValue;

function automatic ExecPkg::word_t modelAlu(ExecPkg::AluCommand cmd, ExecPkg::word_t a,
                                            ExecPkg::word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (cmd)
        ExecPkg::AluCommand_Add:    return a + b;
        ExecPkg::AluCommand_Sub:    return a + ~b + 32'd1;
        ExecPkg::AluCommand_Sll:    return a << sh;
        // signed order by flipping the sign bits
        ExecPkg::AluCommand_Slt:
            return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
        ExecPkg::AluCommand_Sltu:   return (a < b) ? 32'd1 : 32'd0;
        ExecPkg::AluCommand_Xor:    return a ^ b;
        ExecPkg::AluCommand_Srl:    return a >> sh;
        ExecPkg::AluCommand_Sra:
            return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        ExecPkg::AluCommand_Or:     return a | b;
        ExecPkg::AluCommand_And:    return a & b;
        ExecPkg::AluCommand_Clear1: return a & ~b;
        ExecPkg::AluCommand_Clear2: return ~a & b;
        default:                    return 32'h0;
    endcase
endfunction

function automatic logic modelBranch(ExecPkg::BranchType kind, ExecPkg::word_t a,
                                     ExecPkg::word_t b);
    logic signedLess;
    signedLess = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (kind)
        ExecPkg::BranchType_Equal:                return a == b;
        ExecPkg::BranchType_NotEqual:             return a != b;
        ExecPkg::BranchType_LessThan:             return signedLess;
        ExecPkg::BranchType_GreaterEqual:         return !signedLess;
        ExecPkg::BranchType_UnsignedLessThan:     return a < b;
        ExecPkg::BranchType_UnsignedGreaterEqual: return !(a < b);
        ExecPkg::BranchType_Always:               return 1'b1;
        default:                                  return 1'b0;
    endcase
endfunction

function automatic ExecPkg::ExceptionCode ecallCause(ExecPkg::Privilege priv);
    if (priv == ExecPkg::Privilege_User) begin
        return ExecPkg::ExceptionCode_EcallFromUser;
    end
    if (priv == ExecPkg::Privilege_Supervisor) begin
        return ExecPkg::ExceptionCode_EcallFromSupervisor;
    end
    return ExecPkg::ExceptionCode_EcallFromMachine;
endfunction

// x0 never takes the bypass
function automatic ExecPkg::word_t forwardedSource(ExecPkg::regAddr_t addr,
                                                   ExecPkg::word_t value);
    if (lastWriteValid && addr == lastWriteAddr && addr != 5'd0) begin
        return lastWriteValue;
    end
    return value;
endfunction

`endif

// File: tests/ExecuteStageTb.sv
// Execute stage testbench
// random operations from an LFSR, checked one cycle later against a reference model
`timescale 1ns/1ps

module ExecuteStageTb;

    localparam int NUM_OPS = 2000;
    localparam int DRAIN_LIMIT = 20;

    logic clk;
    logic reset;
    logic opValid;
    ExecPkg::word_t pc;
    ExecPkg::word_t insn;
    ExecPkg::AluCommand aluCommand;
    ExecPkg::AluSrc1Type aluSrc1Type;
    ExecPkg::AluSrc2Type aluSrc2Type;
    ExecPkg::word_t imm;
    logic isBranch;
    ExecPkg::BranchType branchType;
    ExecPkg::WriteSrcType writeSrc;
    logic regWrite;
    ExecPkg::regAddr_t dstAddr;
    ExecPkg::regAddr_t srcAddr1;
    ExecPkg::regAddr_t srcAddr2;
    ExecPkg::word_t srcValue1;
    ExecPkg::word_t srcValue2;
    ExecPkg::TrapOpType trapOp;
    ExecPkg::Privilege privilege;
    logic upstreamTrap;
    logic resultValid;
    ExecPkg::word_t resultPc;
    ExecPkg::regAddr_t resultDstAddr;
    logic resultRegWrite;
    ExecPkg::word_t resultValue;
    logic branchTaken;
    ExecPkg::word_t nextPc;
    logic flushReq;
    logic trapValid;
    ExecPkg::ExceptionCode trapCause;
    ExecPkg::word_t trapValue;

    `include "ExecuteModel.svh"

    logic [31:0] lfsrState;
    int errorCount;
    int checkCount;
    int drainCycles;
    logic timedOut;
    ExpectedResult expectQ[$];

    ExecuteStage u_ExecuteStage (.*);

    always #50 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] bits;
        logic feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            bits = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    task automatic compareWord(string name, ExecPkg::word_t want, ExecPkg::word_t got);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, want, got);
        end
    endtask

    task automatic compareBit(string name, logic want, logic got);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, want, got);
        end
    endtask

    task automatic compareAddr(string name, ExecPkg::regAddr_t want, ExecPkg::regAddr_t got);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, want, got);
        end
    endtask

    task automatic compareCause(string name, ExecPkg::ExceptionCode want,
                                ExecPkg::ExceptionCode got);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, want, got);
        end
    endtask

    task automatic checkResult(ExpectedResult want);
        compareBit("resultValid", want.valid, resultValid);
        compareBit("resultRegWrite", want.regWrite, resultRegWrite);
        compareBit("branchTaken", want.taken, branchTaken);
        compareBit("flushReq", want.flush, flushReq);
        compareBit("trapValid", want.trap, trapValid);
        if (want.valid) begin
            compareWord("resultPc", want.pc, resultPc);
            compareAddr("resultDstAddr", want.dstAddr, resultDstAddr);
            compareWord("nextPc", want.nextPc, nextPc);
            if (want.trap) begin
                compareCause("trapCause", want.cause, trapCause);
                compareWord("trapValue", want.trapValue, trapValue);
            end
            else begin
                compareWord("resultValue", want.value, resultValue);
            end
        end
    endtask

    task automatic driveOp();
        ExpectedResult want;
        logic validNow;
        logic branchNow;
        logic regWriteNow;
        logic upTrapNow;
        logic [2:0] trapPick;
        logic [1:0] privPick;
        ExecPkg::word_t pcNow;
        ExecPkg::word_t insnNow;
        ExecPkg::word_t immNow;
        ExecPkg::word_t value1;
        ExecPkg::word_t value2;
        ExecPkg::word_t src1;
        ExecPkg::word_t src2;
        ExecPkg::word_t aluA;
        ExecPkg::word_t aluB;
        ExecPkg::word_t aluOut;
        ExecPkg::regAddr_t dstNow;
        ExecPkg::regAddr_t addr1;
        ExecPkg::regAddr_t addr2;
        ExecPkg::AluCommand cmdNow;
        ExecPkg::AluSrc1Type src1Type;
        ExecPkg::AluSrc2Type src2Type;
        ExecPkg::BranchType kindNow;
        ExecPkg::WriteSrcType writeNow;
        ExecPkg::TrapOpType trapNow;
        ExecPkg::Privilege privNow;
        validNow = randomBits(3) != 0;
        pcNow = randomBits(32) & 32'hffff_fffc;
        insnNow = randomBits(32);
        immNow = randomBits(32);
        cmdNow = ExecPkg::AluCommand'(4'(randomBits(4) % 12));
        src1Type = ExecPkg::AluSrc1Type'(2'(randomBits(2) % 3));
        src2Type = ExecPkg::AluSrc2Type'(2'(randomBits(2) % 3));
        branchNow = randomBits(2) == 0;
        kindNow = ExecPkg::BranchType'(3'(randomBits(3) % 7));
        writeNow = ExecPkg::WriteSrcType'(1'(randomBits(1)));
        regWriteNow = 1'(randomBits(1));
        dstNow = (randomBits(3) == 0) ? 5'd0 : 5'(randomBits(5));
        // lean on the previous destination so the bypass gets exercised
        addr1 = (randomBits(1) != 0) ? lastWriteAddr : 5'(randomBits(5));
        addr2 = (randomBits(1) != 0) ? lastWriteAddr : 5'(randomBits(5));
        value1 = randomBits(32);
        value2 = randomBits(32);
        trapPick = 3'(randomBits(3));
        trapNow = (trapPick == 0) ? ExecPkg::TrapOpType_Ecall :
                  (trapPick == 1) ? ExecPkg::TrapOpType_Ebreak : ExecPkg::TrapOpType_None;
        privPick = 2'(randomBits(2) % 3);
        privNow = (privPick == 0) ? ExecPkg::Privilege_User :
                  (privPick == 1) ? ExecPkg::Privilege_Supervisor : ExecPkg::Privilege_Machine;
        upTrapNow = randomBits(4) == 0;

        src1 = forwardedSource(addr1, value1);
        src2 = forwardedSource(addr2, value2);
        aluA = (src1Type == ExecPkg::AluSrc1Type_Pc) ? pcNow :
               (src1Type == ExecPkg::AluSrc1Type_Reg) ? src1 : 32'h0;
        aluB = (src2Type == ExecPkg::AluSrc2Type_Imm) ? immNow :
               (src2Type == ExecPkg::AluSrc2Type_Reg) ? src2 : 32'h0;
        aluOut = modelAlu(cmdNow, aluA, aluB);

        want.valid = validNow;
        want.pc = pcNow;
        want.dstAddr = dstNow;
        want.trap = validNow && (upTrapNow || trapNow != ExecPkg::TrapOpType_None);
        want.cause = upTrapNow ? ExecPkg::ExceptionCode_IllegalInsn :
                     (trapNow == ExecPkg::TrapOpType_Ecall) ? ecallCause(privNow) :
                     ExecPkg::ExceptionCode_Breakpoint;
        want.trapValue = upTrapNow ? insnNow : 32'h0;
        want.taken = validNow && !want.trap && branchNow && modelBranch(kindNow, src1, src2);
        want.regWrite = validNow && regWriteNow && !want.trap;
        want.value = (writeNow == ExecPkg::WriteSrcType_NextPc) ? pcNow + 32'd4 : aluOut;
        want.nextPc = want.taken ? aluOut : pcNow + 32'd4;
        want.flush = want.trap || want.taken;
        expectQ.push_back(want);

        lastWriteValid = want.regWrite;
        lastWriteAddr = dstNow;
        lastWriteValue = want.value;

        opValid <= validNow;
        pc <= pcNow;
        insn <= insnNow;
        aluCommand <= cmdNow;
        aluSrc1Type <= src1Type;
        aluSrc2Type <= src2Type;
        imm <= immNow;
        isBranch <= branchNow;
        branchType <= kindNow;
        writeSrc <= writeNow;
        regWrite <= regWriteNow;
        dstAddr <= dstNow;
        srcAddr1 <= addr1;
        srcAddr2 <= addr2;
        srcValue1 <= value1;
        srcValue2 <= value2;
        trapOp <= trapNow;
        privilege <= privNow;
        upstreamTrap <= upTrapNow;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        lfsrState = 32'h378c_6e32;
        errorCount = 0;
        checkCount = 0;
        drainCycles = 0;
        timedOut = 1'b0;
        lastWriteValid = 1'b0;
        lastWriteAddr = '0;
        lastWriteValue = '0;
        opValid = 1'b0;
        pc = '0;
        insn = '0;
        aluCommand = ExecPkg::AluCommand_Add;
        aluSrc1Type = ExecPkg::AluSrc1Type_Zero;
        aluSrc2Type = ExecPkg::AluSrc2Type_Zero;
        imm = '0;
        isBranch = 1'b0;
        branchType = ExecPkg::BranchType_Equal;
        writeSrc = ExecPkg::WriteSrcType_Result;
        regWrite = 1'b0;
        dstAddr = '0;
        srcAddr1 = '0;
        srcAddr2 = '0;
        srcValue1 = '0;
        srcValue2 = '0;
        trapOp = ExecPkg::TrapOpType_None;
        privilege = ExecPkg::Privilege_Machine;
        upstreamTrap = 1'b0;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        // stage must come out of reset empty
        compareBit("resultValid", 1'b0, resultValid);
        compareBit("resultRegWrite", 1'b0, resultRegWrite);
        compareBit("branchTaken", 1'b0, branchTaken);
        compareBit("flushReq", 1'b0, flushReq);
        compareBit("trapValid", 1'b0, trapValid);

        for (int n = 0; n < NUM_OPS; n++) begin
            @(posedge clk);
            driveOp();
            @(negedge clk);
            if (expectQ.size() > 1) begin
                checkResult(expectQ.pop_front());
            end
        end

        // stop issuing and wait for the stage to empty
        while ((expectQ.size() > 0 || resultValid !== 1'b0) && drainCycles < DRAIN_LIMIT) begin
            @(posedge clk);
            opValid <= 1'b0;
            @(negedge clk);
            if (expectQ.size() > 0) begin
                checkResult(expectQ.pop_front());
            end
            drainCycles++;
        end
        if (expectQ.size() > 0 || resultValid !== 1'b0) begin
            timedOut = 1'b1;
            $display("stage still busy after %0d drain cycles", DRAIN_LIMIT);
        end

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("Everything OK");
        end
        else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
